// File: src/rv_pkg.sv
package rv_pkg;

  typedef logic [31:0] word_t;      // data word or byte address
  typedef logic [4:0]  reg_addr_t;
  typedef logic [3:0]  byte_sel_t;  // one bit per byte lane
  typedef logic [3:0]  alu_op_t;

  localparam alu_op_t ALU_ADD    = 4'd0;
  localparam alu_op_t ALU_SUB    = 4'd1;
  localparam alu_op_t ALU_AND    = 4'd2;
  localparam alu_op_t ALU_OR     = 4'd3;
  localparam alu_op_t ALU_XOR    = 4'd4;
  localparam alu_op_t ALU_SLT    = 4'd5;
  localparam alu_op_t ALU_SLTU   = 4'd6;
  localparam alu_op_t ALU_SLL    = 4'd7;
  localparam alu_op_t ALU_SRL    = 4'd8;
  localparam alu_op_t ALU_SRA    = 4'd9;
  localparam alu_op_t ALU_PASS_B = 4'd10;  // lui

  // major opcodes
  localparam logic [6:0] OPC_LUI    = 7'b0110111;
  localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
  localparam logic [6:0] OPC_JAL    = 7'b1101111;
  localparam logic [6:0] OPC_JALR   = 7'b1100111;
  localparam logic [6:0] OPC_BRANCH = 7'b1100011;
  localparam logic [6:0] OPC_LOAD   = 7'b0000011;
  localparam logic [6:0] OPC_STORE  = 7'b0100011;
  localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
  localparam logic [6:0] OPC_OP     = 7'b0110011;

  // load and store width
  localparam logic [2:0] F3_BYTE   = 3'b000;
  localparam logic [2:0] F3_HALF   = 3'b001;
  localparam logic [2:0] F3_WORD   = 3'b010;
  localparam logic [2:0] F3_BYTE_U = 3'b100;
  localparam logic [2:0] F3_HALF_U = 3'b101;

  // branch kind
  localparam logic [2:0] F3_BEQ  = 3'b000;
  localparam logic [2:0] F3_BNE  = 3'b001;
  localparam logic [2:0] F3_BLT  = 3'b100;
  localparam logic [2:0] F3_BGE  = 3'b101;
  localparam logic [2:0] F3_BLTU = 3'b110;
  localparam logic [2:0] F3_BGEU = 3'b111;

  typedef enum logic [2:0] {
    S_FETCH,
    S_DECODE,
    S_EXECUTE,
    S_SHIFT,
    S_MEM,
    S_WRITEBACK
  } ctrl_state_t;

endpackage

// File: src/core_ctrl.sv
`timescale 1ns/1ps

module core_ctrl
  import rv_pkg::*;
(
  input  logic clk,
  input  logic rst_n_i,
  input  logic is_load_i,
  input  logic is_store_i,
  input  logic is_shift_i,
  input  logic writes_rd_i,
  input  logic shift_busy_i,
  input  logic bus_done_i,
  output logic bus_req_o,
  output logic bus_data_o,
  output logic ir_load_o,
  output logic exec_start_o,
  output logic rd_we_o,
  output logic pc_update_o
);

  ctrl_state_t state;
  ctrl_state_t state_nxt;

  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      state <= S_FETCH;
    end else begin
      state <= state_nxt;
    end
  end

  always_comb begin
    state_nxt = state;
    case (state)
      S_FETCH: begin
        if (bus_done_i) state_nxt = S_DECODE;  // instruction word on the bus now
      end
      S_DECODE: begin
        state_nxt = S_EXECUTE;
      end
      S_EXECUTE: begin
        if (is_shift_i && shift_busy_i) begin
          state_nxt = S_SHIFT;
        end else if (is_load_i || is_store_i) begin
          state_nxt = S_MEM;
        end else begin
          state_nxt = S_WRITEBACK;
        end
      end
      S_SHIFT: begin
        // busy drops on the last shift cycle
        if (!shift_busy_i) state_nxt = S_WRITEBACK;
      end
      S_MEM: begin
        if (bus_done_i) state_nxt = S_WRITEBACK;
      end
      S_WRITEBACK: begin
        state_nxt = S_FETCH;
      end
      default: begin
        state_nxt = S_FETCH;
      end
    endcase
  end

  // held high for the whole bus state
  assign bus_req_o    = (state == S_FETCH) || (state == S_MEM);
  assign bus_data_o   = (state == S_MEM);

  // single-cycle strobes
  assign ir_load_o    = (state == S_FETCH) && bus_done_i;
  assign exec_start_o = (state == S_EXECUTE);
  assign rd_we_o      = (state == S_WRITEBACK) && writes_rd_i;
  assign pc_update_o  = (state == S_WRITEBACK);

endmodule

// File: src/fetch_decode.sv
`timescale 1ns/1ps

module fetch_decode
  import rv_pkg::*;
#(
  parameter word_t RESET_PC = 32'h0000_0000
) (
  input  logic       clk,
  input  logic       rst_n_i,
  input  logic       ir_load_i,
  input  logic       pc_update_i,
  input  word_t      wb_dat_i,
  input  word_t      next_pc_i,
  output word_t      pc_o,
  output reg_addr_t  rs1_o,
  output reg_addr_t  rs2_o,
  output reg_addr_t  rd_o,
  output word_t      imm_o,
  output logic [2:0] funct3_o,
  output alu_op_t    alu_op_o,
  output logic       use_imm_o,
  output logic       use_pc_o,
  output logic       is_load_o,
  output logic       is_store_o,
  output logic       is_shift_o,
  output logic       is_branch_o,
  output logic       is_jal_o,
  output logic       is_jalr_o,
  output logic       writes_rd_o
);

  word_t      ir;
  logic [6:0] opcode;
  word_t      imm_i_type;
  word_t      imm_s_type;
  word_t      imm_b_type;
  word_t      imm_u_type;
  word_t      imm_j_type;
  alu_op_t    alu_fn;

  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      pc_o <= RESET_PC;
    end else if (pc_update_i) begin
      pc_o <= next_pc_i;
    end
  end

  always_ff @(posedge clk) begin
    if (ir_load_i) ir <= wb_dat_i;
  end

  assign opcode   = ir[6:0];
  assign rd_o     = ir[11:7];
  assign funct3_o = ir[14:12];
  assign rs1_o    = ir[19:15];
  assign rs2_o    = ir[24:20];

  assign imm_i_type = {{20{ir[31]}}, ir[31:20]};
  assign imm_s_type = {{20{ir[31]}}, ir[31:25], ir[11:7]};
  assign imm_b_type = {{19{ir[31]}}, ir[31], ir[7], ir[30:25], ir[11:8], 1'b0};
  assign imm_u_type = {ir[31:12], 12'b0};
  assign imm_j_type = {{11{ir[31]}}, ir[31], ir[19:12], ir[20], ir[30:21], 1'b0};

  // funct3 to alu op, shared by op and op-imm
  always_comb begin
    case (funct3_o)
      3'b000:  alu_fn = (opcode == OPC_OP && ir[30]) ? ALU_SUB : ALU_ADD;
      3'b001:  alu_fn = ALU_SLL;
      3'b010:  alu_fn = ALU_SLT;
      3'b011:  alu_fn = ALU_SLTU;
      3'b100:  alu_fn = ALU_XOR;
      3'b101:  alu_fn = ir[30] ? ALU_SRA : ALU_SRL;
      3'b110:  alu_fn = ALU_OR;
      default: alu_fn = ALU_AND;
    endcase
  end

  always_comb begin
    imm_o       = imm_i_type;
    alu_op_o    = ALU_ADD;
    use_imm_o   = 1'b0;
    use_pc_o    = 1'b0;
    is_load_o   = 1'b0;
    is_store_o  = 1'b0;
    is_branch_o = 1'b0;
    is_jal_o    = 1'b0;
    is_jalr_o   = 1'b0;
    writes_rd_o = 1'b0;  // unknown opcodes fall through as nops
    case (opcode)
      OPC_LUI: begin
        imm_o       = imm_u_type;
        alu_op_o    = ALU_PASS_B;
        use_imm_o   = 1'b1;
        writes_rd_o = 1'b1;
      end
      OPC_AUIPC: begin
        imm_o       = imm_u_type;
        use_imm_o   = 1'b1;
        use_pc_o    = 1'b1;
        writes_rd_o = 1'b1;
      end
      OPC_JAL: begin
        imm_o       = imm_j_type;
        is_jal_o    = 1'b1;
        writes_rd_o = 1'b1;
      end
      OPC_JALR: begin
        is_jalr_o   = 1'b1;
        writes_rd_o = 1'b1;
      end
      OPC_BRANCH: begin
        imm_o       = imm_b_type;
        is_branch_o = 1'b1;
      end
      OPC_LOAD: begin
        use_imm_o   = 1'b1;
        is_load_o   = 1'b1;
        writes_rd_o = 1'b1;
      end
      OPC_STORE: begin
        imm_o      = imm_s_type;
        use_imm_o  = 1'b1;
        is_store_o = 1'b1;
      end
      OPC_OP_IMM: begin
        alu_op_o    = alu_fn;
        use_imm_o   = 1'b1;
        writes_rd_o = 1'b1;
      end
      OPC_OP: begin
        alu_op_o    = alu_fn;
        writes_rd_o = 1'b1;
      end
      default: begin
        imm_o = imm_i_type;
      end
    endcase
  end

  assign is_shift_o = (opcode == OPC_OP || opcode == OPC_OP_IMM) &&
                      (alu_fn inside {ALU_SLL, ALU_SRL, ALU_SRA});

endmodule

// File: src/reg_file.sv
`timescale 1ns/1ps

module reg_file
  import rv_pkg::*;
(
  input  logic      clk,
  input  logic      rst_n_i,
  input  reg_addr_t rs1_i,
  input  reg_addr_t rs2_i,
  input  reg_addr_t rd_i,
  input  logic      we_i,
  input  logic      is_load_i,
  input  word_t     alu_result_i,
  input  word_t     load_data_i,
  output word_t     rs1_data_o,
  output word_t     rs2_data_o
);

  word_t regs [32];
  word_t wr_data;

  assign wr_data = is_load_i ? load_data_i : alu_result_i;

  // no writes while held in reset
  always_ff @(posedge clk) begin
    if (rst_n_i && we_i && rd_i != 5'd0) regs[rd_i] <= wr_data;
  end

  assign rs1_data_o = (rs1_i == 5'd0) ? 32'd0 : regs[rs1_i];  // x0 reads zero
  assign rs2_data_o = (rs2_i == 5'd0) ? 32'd0 : regs[rs2_i];

endmodule

// File: src/exec_unit.sv
`timescale 1ns/1ps

module exec_unit
  import rv_pkg::*;
(
  input  logic       clk,
  input  logic       rst_n_i,
  input  logic       start_i,
  input  word_t      pc_i,
  input  word_t      imm_i,
  input  word_t      rs1_data_i,
  input  word_t      rs2_data_i,
  input  alu_op_t    alu_op_i,
  input  logic [2:0] funct3_i,
  input  logic       use_imm_i,
  input  logic       use_pc_i,
  input  logic       is_branch_i,
  input  logic       is_jal_i,
  input  logic       is_jalr_i,
  output word_t      alu_result_o,
  output word_t      next_pc_o,
  output logic       shift_busy_o
);

  word_t      op_a;
  word_t      op_b;
  word_t      alu_out;
  word_t      link_addr;
  word_t      jalr_target;
  logic [4:0] shamt;
  logic [4:0] shift_cnt;  // shifts still to do
  logic       is_shift_op;
  logic       shift_req;
  logic       taken;

  assign op_a        = use_pc_i ? pc_i : rs1_data_i;
  assign op_b        = use_imm_i ? imm_i : rs2_data_i;
  assign shamt       = op_b[4:0];
  assign link_addr   = pc_i + 32'd4;
  assign jalr_target = (rs1_data_i + imm_i) & ~32'd1;

  assign is_shift_op = alu_op_i inside {ALU_SLL, ALU_SRL, ALU_SRA};
  assign shift_req   = is_shift_op && (shamt != 5'd0);

  // low on the final shift cycle, so the shift state lasts shamt cycles
  assign shift_busy_o = start_i ? shift_req : (shift_cnt > 5'd1);

  always_comb begin
    case (alu_op_i)
      ALU_ADD:    alu_out = op_a + op_b;
      ALU_SUB:    alu_out = op_a - op_b;
      ALU_AND:    alu_out = op_a & op_b;
      ALU_OR:     alu_out = op_a | op_b;
      ALU_XOR:    alu_out = op_a ^ op_b;
      ALU_SLT:    alu_out = {31'd0, $signed(op_a) < $signed(op_b)};
      ALU_SLTU:   alu_out = {31'd0, op_a < op_b};
      ALU_PASS_B: alu_out = op_b;
      default:    alu_out = op_a;  // shifts start from the unshifted value
    endcase
  end

  always_comb begin
    case (funct3_i)
      F3_BEQ:  taken = (rs1_data_i == rs2_data_i);
      F3_BNE:  taken = (rs1_data_i != rs2_data_i);
      F3_BLT:  taken = $signed(rs1_data_i) < $signed(rs2_data_i);
      F3_BGE:  taken = $signed(rs1_data_i) >= $signed(rs2_data_i);
      F3_BLTU: taken = rs1_data_i < rs2_data_i;
      F3_BGEU: taken = rs1_data_i >= rs2_data_i;
      default: taken = 1'b0;
    endcase
  end

  always_comb begin
    if (is_jalr_i) begin
      next_pc_o = jalr_target;
    end else if (is_jal_i || (is_branch_i && taken)) begin
      next_pc_o = pc_i + imm_i;
    end else begin
      next_pc_o = link_addr;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      shift_cnt <= 5'd0;
    end else if (start_i) begin
      shift_cnt <= is_shift_op ? shamt : 5'd0;
    end else if (shift_cnt != 5'd0) begin
      shift_cnt <= shift_cnt - 5'd1;
    end
  end

  // one bit per cycle while the counter runs
  always_ff @(posedge clk) begin
    if (start_i) begin
      alu_result_o <= (is_jal_i || is_jalr_i) ? link_addr : alu_out;
    end else if (shift_cnt != 5'd0) begin
      case (alu_op_i)
        ALU_SRL: alu_result_o <= {1'b0, alu_result_o[31:1]};
        ALU_SRA: alu_result_o <= {alu_result_o[31], alu_result_o[31:1]};
        default: alu_result_o <= {alu_result_o[30:0], 1'b0};
      endcase
    end
  end

endmodule

// File: src/wb_master.sv
`timescale 1ns/1ps

module wb_master
  import rv_pkg::*;
(
  input  logic       clk,
  input  logic       rst_n_i,
  input  logic       bus_req_i,
  input  logic       bus_data_i,
  input  logic       is_store_i,
  input  word_t      pc_i,
  input  word_t      addr_i,
  input  word_t      store_data_i,
  input  logic [2:0] funct3_i,
  output logic       wb_cyc_o,
  output logic       wb_stb_o,
  output logic       wb_we_o,
  output word_t      wb_adr_o,
  output byte_sel_t  wb_sel_o,
  output word_t      wb_dat_o,
  input  word_t      wb_dat_i,
  input  logic       wb_ack_i,
  output logic       bus_done_o,
  output word_t      load_data_o
);

  logic      cyc_q;
  logic      launch;
  byte_sel_t sel_d;
  word_t     dat_d;
  word_t     lane_word;
  word_t     load_ext;

  assign wb_cyc_o   = cyc_q;
  assign wb_stb_o   = cyc_q;  // single transfers only
  assign bus_done_o = cyc_q & wb_ack_i;
  assign launch     = bus_req_i & ~cyc_q;

  // store lanes, fetches read the full word
  always_comb begin
    sel_d = 4'b1111;
    dat_d = store_data_i;
    if (bus_data_i) begin
      case (funct3_i)
        F3_BYTE: begin
          sel_d = byte_sel_t'(4'b0001 << addr_i[1:0]);
          dat_d = {4{store_data_i[7:0]}};
        end
        F3_HALF: begin
          sel_d = addr_i[1] ? 4'b1100 : 4'b0011;
          dat_d = {2{store_data_i[15:0]}};
        end
        default: begin
          sel_d = 4'b1111;
        end
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      cyc_q   <= 1'b0;
      wb_we_o <= 1'b0;
    end else if (bus_done_o) begin
      cyc_q   <= 1'b0;  // drop on the acked edge
      wb_we_o <= 1'b0;
    end else if (launch) begin
      cyc_q   <= 1'b1;
      wb_we_o <= bus_data_i & is_store_i;
    end
  end

  // address, select and data held until ack
  always_ff @(posedge clk) begin
    if (launch) begin
      wb_adr_o <= bus_data_i ? addr_i : pc_i;
      wb_sel_o <= sel_d;
      wb_dat_o <= dat_d;
    end
  end

  assign lane_word = wb_dat_i >> {wb_adr_o[1:0], 3'b000};

  always_comb begin
    case (funct3_i)
      F3_BYTE:   load_ext = {{24{lane_word[7]}}, lane_word[7:0]};
      F3_HALF:   load_ext = {{16{lane_word[15]}}, lane_word[15:0]};
      F3_BYTE_U: load_ext = {24'd0, lane_word[7:0]};
      F3_HALF_U: load_ext = {16'd0, lane_word[15:0]};
      F3_WORD:   load_ext = wb_dat_i;
      default:   load_ext = wb_dat_i;
    endcase
  end

  always_ff @(posedge clk) begin
    if (bus_done_o && !wb_we_o) load_data_o <= load_ext;
  end

endmodule

// File: src/rv_core.sv
`timescale 1ns/1ps

module rv_core
  import rv_pkg::*;
#(
  parameter word_t RESET_PC = 32'h0000_0000
) (
  input  logic      clk,
  input  logic      rst_n_i,
  output logic      wb_cyc_o,
  output logic      wb_stb_o,
  output logic      wb_we_o,
  output word_t     wb_adr_o,
  output byte_sel_t wb_sel_o,
  output word_t     wb_dat_o,
  input  word_t     wb_dat_i,
  input  logic      wb_ack_i
);

  // controller strobes
  logic bus_req;
  logic bus_data;
  logic bus_done;
  logic ir_load;
  logic exec_start;
  logic rd_we;
  logic pc_update;

  // decoded instruction
  word_t      pc;
  reg_addr_t  rs1;
  reg_addr_t  rs2;
  reg_addr_t  rd;
  word_t      imm;
  logic [2:0] funct3;
  alu_op_t    alu_op;
  logic       use_imm;
  logic       use_pc;
  logic       is_load;
  logic       is_store;
  logic       is_shift;
  logic       is_branch;
  logic       is_jal;
  logic       is_jalr;
  logic       writes_rd;

  word_t rs1_data;
  word_t rs2_data;
  word_t alu_result;
  word_t next_pc;
  logic  shift_busy;
  word_t load_data;

  core_ctrl u_ctrl (
    .clk          (clk),
    .rst_n_i      (rst_n_i),
    .is_load_i    (is_load),
    .is_store_i   (is_store),
    .is_shift_i   (is_shift),
    .writes_rd_i  (writes_rd),
    .shift_busy_i (shift_busy),
    .bus_done_i   (bus_done),
    .bus_req_o    (bus_req),
    .bus_data_o   (bus_data),
    .ir_load_o    (ir_load),
    .exec_start_o (exec_start),
    .rd_we_o      (rd_we),
    .pc_update_o  (pc_update)
  );

  fetch_decode #(
    .RESET_PC (RESET_PC)
  ) u_fetch_decode (
    .clk         (clk),
    .rst_n_i     (rst_n_i),
    .ir_load_i   (ir_load),
    .pc_update_i (pc_update),
    .wb_dat_i    (wb_dat_i),
    .next_pc_i   (next_pc),
    .pc_o        (pc),
    .rs1_o       (rs1),
    .rs2_o       (rs2),
    .rd_o        (rd),
    .imm_o       (imm),
    .funct3_o    (funct3),
    .alu_op_o    (alu_op),
    .use_imm_o   (use_imm),
    .use_pc_o    (use_pc),
    .is_load_o   (is_load),
    .is_store_o  (is_store),
    .is_shift_o  (is_shift),
    .is_branch_o (is_branch),
    .is_jal_o    (is_jal),
    .is_jalr_o   (is_jalr),
    .writes_rd_o (writes_rd)
  );

  reg_file u_reg_file (
    .clk          (clk),
    .rst_n_i      (rst_n_i),
    .rs1_i        (rs1),
    .rs2_i        (rs2),
    .rd_i         (rd),
    .we_i         (rd_we),
    .is_load_i    (is_load),
    .alu_result_i (alu_result),
    .load_data_i  (load_data),
    .rs1_data_o   (rs1_data),
    .rs2_data_o   (rs2_data)
  );

  exec_unit u_exec (
    .clk          (clk),
    .rst_n_i      (rst_n_i),
    .start_i      (exec_start),
    .pc_i         (pc),
    .imm_i        (imm),
    .rs1_data_i   (rs1_data),
    .rs2_data_i   (rs2_data),
    .alu_op_i     (alu_op),
    .funct3_i     (funct3),
    .use_imm_i    (use_imm),
    .use_pc_i     (use_pc),
    .is_branch_i  (is_branch),
    .is_jal_i     (is_jal),
    .is_jalr_i    (is_jalr),
    .alu_result_o (alu_result),
    .next_pc_o    (next_pc),
    .shift_busy_o (shift_busy)
  );

  wb_master u_wb_master (
    .clk          (clk),
    .rst_n_i      (rst_n_i),
    .bus_req_i    (bus_req),
    .bus_data_i   (bus_data),
    .is_store_i   (is_store),
    .pc_i         (pc),
    .addr_i       (alu_result),  // rs1 + offset from execute
    .store_data_i (rs2_data),
    .funct3_i     (funct3),
    .wb_cyc_o     (wb_cyc_o),
    .wb_stb_o     (wb_stb_o),
    .wb_we_o      (wb_we_o),
    .wb_adr_o     (wb_adr_o),
    .wb_sel_o     (wb_sel_o),
    .wb_dat_o     (wb_dat_o),
    .wb_dat_i     (wb_dat_i),
    .wb_ack_i     (wb_ack_i),
    .bus_done_o   (bus_done),
    .load_data_o  (load_data)
  );

endmodule

// File: sim/rv_core_assertions.sv
`timescale 1ns/1ps

module rv_core_assertions
  import rv_pkg::*;
(
  input logic      clk,
  input logic      rst_n_i,
  input logic      wb_cyc_o,
  input logic      wb_stb_o,
  input logic      wb_we_o,
  input word_t     wb_adr_o,
  input byte_sel_t wb_sel_o,
  input word_t     wb_dat_o,
  input logic      wb_ack_i
);

  // bus idle coming out of a reset edge
  reset_idle: assert property (@(posedge clk) !rst_n_i |=> !wb_cyc_o && !wb_stb_o && !wb_we_o)
    else $error("bus active after a reset edge");

  // request held with all its fields until the slave answers
  hold_until_ack: assert property (@(posedge clk) disable iff (!rst_n_i)
    wb_stb_o && !wb_ack_i |=> wb_stb_o && $stable(wb_adr_o) && $stable(wb_we_o) &&
                              $stable(wb_sel_o) && $stable(wb_dat_o))
    else $error("request changed before ack");

  drop_on_ack: assert property (@(posedge clk) disable iff (!rst_n_i) wb_ack_i |=> !wb_stb_o)
    else $error("stb still high after the acked edge");

endmodule

// File: sim/tb_rv_core.sv
`timescale 1ns/1ps

module tb_rv_core
  import rv_pkg::*;
;

  localparam word_t RESET_PC  = 32'h0000_0000;
  localparam word_t DONE_ADDR = 32'h0000_07fc;

  logic      clk = 1'b0;
  logic      rst_n_i;
  logic      wb_cyc_o;
  logic      wb_stb_o;
  logic      wb_we_o;
  word_t     wb_adr_o;
  byte_sel_t wb_sel_o;
  word_t     wb_dat_o;
  word_t     wb_dat_i = 32'd0;
  logic      wb_ack_i = 1'b0;

  word_t     mem [1024];
  word_t     exp_adr [$];
  byte_sel_t exp_sel [$];
  word_t     exp_dat [$];
  integer    seed;
  int        waits = -1;
  int        limit_cycles = 0;
  int        prog_len;
  int        slot;

  rv_core #(.RESET_PC(RESET_PC)) dut0 (.*);

  bind rv_core rv_core_assertions u_assertions (.*);

  always #20 clk = ~clk;

  task automatic value_mismatch(input string msg);
    $display("FAILED at %0t ns: %s", $time, msg);
    $display("Regression failed");
    $fatal(1, "wrong value");
  endtask

  task automatic report_failure(input string msg);
    $display("%s", msg);
    $display("Regression failed");
    $fatal(1, "check failed");
  endtask

  function automatic word_t r_type(int f7, int rs2, int rs1, logic [2:0] f3, int rd,
                                   logic [6:0] opc);
    return {f7[6:0], rs2[4:0], rs1[4:0], f3, rd[4:0], opc};
  endfunction

  function automatic word_t i_type(int imm, int rs1, logic [2:0] f3, int rd, logic [6:0] opc);
    return {imm[11:0], rs1[4:0], f3, rd[4:0], opc};
  endfunction

  function automatic word_t s_type(int imm, int rs2, int rs1, logic [2:0] f3);
    return {imm[11:5], rs2[4:0], rs1[4:0], f3, imm[4:0], OPC_STORE};
  endfunction

  function automatic word_t b_type(int imm, int rs2, int rs1, logic [2:0] f3);
    return {imm[12], imm[10:5], rs2[4:0], rs1[4:0], f3, imm[4:1], imm[11], OPC_BRANCH};
  endfunction

  function automatic word_t u_type(int imm, int rd, logic [6:0] opc);
    return {imm[19:0], rd[4:0], opc};
  endfunction

  function automatic word_t j_type(int imm, int rd);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd[4:0], OPC_JAL};
  endfunction

  task automatic emit(input word_t w);
    mem[prog_len] = w;
    prog_len++;
  endtask

  // each result gets its own word above 0x600 (x2)
  task automatic save_result(input int rs);
    emit(s_type(slot * 4, rs, 2, F3_WORD));
    slot++;
  endtask

  task automatic build_program();
    logic [2:0] kinds [6];
    int         amt;
    kinds = '{F3_BEQ, F3_BNE, F3_BLT, F3_BGE, F3_BLTU, F3_BGEU};
    for (int i = 0; i < 1024; i++) mem[i] = 32'h5a5a_0000 ^ word_t'(i * 4);
    for (int i = 0; i < 8; i++) mem[256 + i] = $random(seed);  // operands at 0x400
    prog_len = 0;
    slot = 0;
    emit(i_type(12'h400, 0, 3'b000, 1, OPC_OP_IMM));
    emit(i_type(12'h600, 0, 3'b000, 2, OPC_OP_IMM));
    emit(i_type(12'h03c, 0, 3'b000, 13, OPC_OP_IMM));  // marker value
    for (int i = 0; i < 4; i++) emit(i_type(i * 4, 1, F3_WORD, 5 + i, OPC_LOAD));
    for (int f = 0; f < 8; f++) begin
      emit(r_type(0, 6, 5, 3'(f), 10, OPC_OP));
      save_result(10);
    end
    emit(r_type(32, 6, 5, 3'b000, 10, OPC_OP));  // sub
    save_result(10);
    emit(r_type(0, 8, 7, 3'b010, 10, OPC_OP));
    save_result(10);
    emit(r_type(0, 8, 7, 3'b011, 10, OPC_OP));
    save_result(10);
    emit(i_type(-123, 5, 3'b000, 10, OPC_OP_IMM));
    save_result(10);
    emit(i_type(12'h5a5, 6, 3'b111, 10, OPC_OP_IMM));
    save_result(10);
    emit(i_type(12'h0f0, 7, 3'b110, 10, OPC_OP_IMM));
    save_result(10);
    emit(i_type(-1, 7, 3'b100, 10, OPC_OP_IMM));
    save_result(10);
    emit(i_type(7, 5, 3'b010, 10, OPC_OP_IMM));
    save_result(10);
    emit(i_type(-1, 6, 3'b011, 10, OPC_OP_IMM));
    save_result(10);
    emit(u_type(20'habcde, 10, OPC_LUI));
    save_result(10);
    emit(u_type(20'h12345, 10, OPC_AUIPC));
    save_result(10);
    // shifts by 0, 31 and two random amounts
    for (int k = 0; k < 4; k++) begin
      amt = (k == 0) ? 0 : (k == 1) ? 31 : ($random(seed) & 31);
      emit(i_type(amt, 5, 3'b001, 10, OPC_OP_IMM));
      save_result(10);
      emit(i_type(amt, 6, 3'b101, 10, OPC_OP_IMM));
      save_result(10);
      emit(i_type(amt | 12'h400, 7, 3'b101, 10, OPC_OP_IMM));
      save_result(10);
      emit(i_type(amt, 0, 3'b000, 11, OPC_OP_IMM));
      emit(r_type(0, 11, 5, 3'b001, 10, OPC_OP));
      save_result(10);
      emit(r_type(0, 11, 6, 3'b101, 10, OPC_OP));
      save_result(10);
      emit(r_type(32, 11, 7, 3'b101, 10, OPC_OP));
      save_result(10);
    end
    emit(r_type(32, 8, 5, 3'b101, 10, OPC_OP));  // amount from a random word
    save_result(10);
    // taken branches skip the marker store
    for (int k = 0; k < 6; k++) begin
      emit(b_type(8, 6, 5, kinds[k]));
      save_result(13);
      emit(b_type(8, 5, 6, kinds[k]));
      save_result(13);
      emit(b_type(8, 5, 5, kinds[k]));
      save_result(13);
    end
    emit(j_type(8, 14));
    save_result(13);
    save_result(14);
    emit(u_type(0, 15, OPC_AUIPC));
    emit(i_type(13, 15, 3'b000, 14, OPC_JALR));  // odd target with bit 0 cleared
    save_result(13);
    save_result(14);
    save_result(15);
    for (int b = 0; b < 4; b++) emit(s_type(slot * 4 + b, 6, 2, F3_BYTE));
    slot++;
    emit(s_type(slot * 4, 7, 2, F3_HALF));
    emit(s_type(slot * 4 + 2, 8, 2, F3_HALF));
    slot++;
    for (int b = 0; b < 4; b++) begin
      emit(i_type(16 + b, 1, F3_BYTE, 10, OPC_LOAD));
      save_result(10);
      emit(i_type(16 + b, 1, F3_BYTE_U, 10, OPC_LOAD));
      save_result(10);
    end
    for (int b = 0; b < 4; b += 2) begin
      emit(i_type(20 + b, 1, F3_HALF, 10, OPC_LOAD));
      save_result(10);
      emit(i_type(20 + b, 1, F3_HALF_U, 10, OPC_LOAD));
      save_result(10);
    end
    emit(s_type(12'h1fc, 5, 2, F3_WORD));  // done address
    emit(j_type(0, 0));
  endtask

  function automatic word_t alu_ref(logic [2:0] f3, logic alt, logic is_reg, word_t a,
                                    word_t b);
    case (f3)
      3'b000:  return (alt && is_reg) ? a - b : a + b;
      3'b001:  return a << b[4:0];
      3'b010:  return {31'd0, $signed(a) < $signed(b)};
      3'b011:  return {31'd0, a < b};
      3'b100:  return a ^ b;
      3'b101:  return alt ? word_t'($signed(a) >>> b[4:0]) : a >> b[4:0];
      3'b110:  return a | b;
      default: return a & b;
    endcase
  endfunction

  // ISA model over a copy of the image; records every store in order
  function automatic int rv_model();
    word_t      r [32];
    word_t      m [1024];
    word_t      pc;
    word_t      ir;
    word_t      a;
    word_t      b;
    word_t      res;
    word_t      addr;
    word_t      w;
    word_t      npc;
    logic [2:0] f3;
    byte_sel_t  sel;
    logic       wr;
    logic       taken;
    logic       done;
    int         steps;
    for (int i = 0; i < 32; i++) r[i] = 32'd0;
    for (int i = 0; i < 1024; i++) m[i] = mem[i];
    pc = RESET_PC;
    done = 1'b0;
    steps = 0;
    while (!done && steps < 20000) begin
      ir = m[pc[11:2]];
      f3 = ir[14:12];
      a = r[ir[19:15]];
      b = r[ir[24:20]];
      npc = pc + 32'd4;
      wr = 1'b1;
      res = 32'd0;
      case (ir[6:0])
        OPC_LUI:   res = {ir[31:12], 12'd0};
        OPC_AUIPC: res = pc + {ir[31:12], 12'd0};
        OPC_JAL: begin
          res = pc + 32'd4;
          npc = pc + {{12{ir[31]}}, ir[19:12], ir[20], ir[30:21], 1'b0};
        end
        OPC_JALR: begin
          res = pc + 32'd4;
          npc = (a + {{20{ir[31]}}, ir[31:20]}) & ~32'd1;
        end
        OPC_BRANCH: begin
          wr = 1'b0;
          case (f3)
            F3_BEQ:  taken = a == b;
            F3_BNE:  taken = a != b;
            F3_BLT:  taken = $signed(a) < $signed(b);
            F3_BGE:  taken = $signed(a) >= $signed(b);
            F3_BLTU: taken = a < b;
            F3_BGEU: taken = a >= b;
            default: taken = 1'b0;
          endcase
          if (taken) npc = pc + {{20{ir[31]}}, ir[7], ir[30:25], ir[11:8], 1'b0};
        end
        OPC_LOAD: begin
          addr = a + {{20{ir[31]}}, ir[31:20]};
          w = m[addr[11:2]] >> {addr[1:0], 3'b000};
          case (f3)
            F3_BYTE:   res = {{24{w[7]}}, w[7:0]};
            F3_HALF:   res = {{16{w[15]}}, w[15:0]};
            F3_BYTE_U: res = {24'd0, w[7:0]};
            F3_HALF_U: res = {16'd0, w[15:0]};
            default:   res = w;
          endcase
        end
        OPC_STORE: begin
          wr = 1'b0;
          addr = a + {{20{ir[31]}}, ir[31:25], ir[11:7]};
          case (f3)
            F3_BYTE: sel = 4'b0001 << addr[1:0];
            F3_HALF: sel = 4'b0011 << addr[1:0];
            default: sel = 4'b1111;
          endcase
          w = b << {addr[1:0], 3'b000};
          exp_adr.push_back(addr);
          exp_sel.push_back(sel);
          exp_dat.push_back(w);
          for (int k = 0; k < 4; k++) begin
            if (sel[k]) m[addr[11:2]][8 * k +: 8] = w[8 * k +: 8];
          end
          done = (addr == DONE_ADDR);
        end
        OPC_OP_IMM: res = alu_ref(f3, ir[30], 1'b0, a, {{20{ir[31]}}, ir[31:20]});
        OPC_OP:     res = alu_ref(f3, ir[30], 1'b1, a, b);
        default:    wr = 1'b0;
      endcase
      if (wr && ir[11:7] != 5'd0) r[ir[11:7]] = res;
      pc = npc;
      steps++;
    end
    return steps;
  endfunction

  function automatic word_t lane_mask(byte_sel_t sel);
    return {{8{sel[3]}}, {8{sel[2]}}, {8{sel[1]}}, {8{sel[0]}}};
  endfunction

  // memory slave with 0 to 3 wait states per transfer
  always @(posedge clk) begin
    #2;
    if (wb_ack_i) begin
      wb_ack_i = 1'b0;
      waits = -1;
    end else if (rst_n_i && wb_stb_o) begin
      if (waits < 0) waits = $random(seed) & 3;
      if (waits == 0) begin
        if (wb_we_o) begin
          for (int k = 0; k < 4; k++) begin
            if (wb_sel_o[k]) mem[wb_adr_o[11:2]][8 * k +: 8] = wb_dat_o[8 * k +: 8];
          end
        end
        wb_dat_i = mem[wb_adr_o[11:2]];
        wb_ack_i = 1'b1;
      end else begin
        waits--;
      end
    end
  end

  task automatic finish_run();
    $display("Regression passed");
    $finish;
  endtask

  // compare each acked write mid-cycle
  always @(negedge clk) begin
    word_t     ea;
    byte_sel_t es;
    word_t     ed;
    if (rst_n_i && wb_cyc_o && wb_stb_o && wb_we_o && wb_ack_i) begin
      assert (exp_adr.size() != 0) begin
        ea = exp_adr.pop_front();
        es = exp_sel.pop_front();
        ed = exp_dat.pop_front();
        assert (wb_adr_o == ea && wb_sel_o == es &&
                (wb_dat_o & lane_mask(es)) == (ed & lane_mask(es))) begin
          if (ea == DONE_ADDR) finish_run();
        end else begin
          value_mismatch($sformatf("store adr %h sel %b dat %h, expected adr %h sel %b dat %h",
                                   wb_adr_o, wb_sel_o, wb_dat_o, ea, es, ed));
        end
      end else begin
        report_failure("The core wrote to memory after all expected stores were seen");
      end
    end
  end

  initial begin
    wait (limit_cycles > 0);
    repeat (limit_cycles) @(posedge clk);
    $display("Timeout: the program did not reach the done address in %0d cycles",
             limit_cycles);
    $display("Regression failed");
    $fatal(1, "watchdog expired");
  end

  initial begin
    rst_n_i = 1'b0;
    seed = 32'hf24ba8a3;
    build_program();
    limit_cycles = rv_model() * 60 * 4;
    repeat (5) begin
      @(posedge clk);
      #1;
      assert (!wb_cyc_o && !wb_stb_o && !wb_we_o)
        else report_failure("Bus was active during reset");
    end
    #1 rst_n_i = 1'b1;
    @(posedge clk);
    #1;
    assert (wb_cyc_o && wb_stb_o && !wb_we_o && wb_adr_o == RESET_PC)
      else value_mismatch($sformatf("first cycle cyc %b we %b adr %h, expected read at %h",
                                    wb_cyc_o, wb_we_o, wb_adr_o, RESET_PC));
  end

endmodule

// File: rv_core.f
src/rv_pkg.sv
src/core_ctrl.sv
src/fetch_decode.sv
src/reg_file.sv
src/exec_unit.sv
src/wb_master.sv
src/rv_core.sv
sim/rv_core_assertions.sv
sim/tb_rv_core.sv

// File: Makefile
TOP := tb_rv_core

.PHONY: all lint clean

all: obj_dir/V$(TOP)
	./obj_dir/V$(TOP)

obj_dir/V$(TOP): rv_core.f src/*.sv sim/*.sv
	verilator --binary --timing --assert -j 0 -f rv_core.f --top-module $(TOP)

lint:
	verilator --lint-only --timing --assert -f rv_core.f --top-module $(TOP)

clean:
	rm -rf obj_dir
